/* bench/cpu_tb_programs.svh */
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

// operands used by the programs
localparam word_t P0_VALUE    = 16'h7ff0;
localparam word_t P0_ADD      = 16'h9123;
localparam word_t P0_SUB      = 16'h0456;
localparam word_t P1_A        = 16'h1234;
localparam word_t P1_B        = 16'hf00d;
localparam word_t P2_VAL      = 16'h2222;
localparam word_t P3_VAL      = 16'h3333;
localparam word_t SKIP_MARK   = 16'hbeef;  // target of the skipped store
localparam word_t RESULT_MARK = 16'ha5a5;  // result slots start with this

localparam int PROG_LEN = 28;

// one page 0 image per process, words 2 to 7 are data and code starts at 8
localparam word_t PROGS [N_PROC][PROG_LEN] = '{
  '{ {OP_JMP, 8'd0}, 16'd8, 16'h0, 16'h0,
     SKIP_MARK, RESULT_MARK, 16'h0, 16'h0,
     {OP_IMM, 8'd1}, P0_VALUE, {OP_ADD, 8'd1}, P0_ADD,
     {OP_SUB, 8'd1}, P0_SUB, {OP_STORE, 8'd1}, 16'd5,
     {OP_JMP, 8'd0}, 16'd20, {OP_STORE, 8'd1}, 16'd4,  // jump over a store to word 4
     {OP_JMP, 8'd0}, 16'd20, 16'h0, 16'h0,
     16'h0, 16'h0, 16'h0, 16'h0 },
  '{ {OP_JMP, 8'd0}, 16'd8, 16'h0, 16'h0,
     16'h0, 16'h0, RESULT_MARK, 16'h0,
     {OP_IMM, 8'd1}, P1_A, {OP_IMM, 8'd2}, P1_B,
     {OP_STORE, 8'd1}, 16'd100, {OP_STORE, 8'd2}, 16'd200,
     {OP_LOAD, 8'd3}, 16'd100, {OP_LOAD, 8'd4}, 16'd200,
     {OP_STORE, 8'd4}, 16'd23, {OP_ADD, 8'd3}, 16'h0,  // add operand is patched by the store
     {OP_STORE, 8'd3}, 16'd6, {OP_JMP, 8'd0}, 16'd26 },
  '{ {OP_JMP, 8'd0}, 16'd8, 16'h0, 16'h0,
     16'h0, 16'h0, 16'h0, RESULT_MARK,
     {OP_IMM, 8'd1}, P2_VAL, {OP_STORE, 8'd1}, 16'd100,
     {OP_IMM, 8'd1}, 16'h0, 16'h0, 16'h0,  // nops push the load into the next slice
     16'h0, 16'h0, 16'h0, 16'h0,
     16'h0, 16'h0, {OP_LOAD, 8'd2}, 16'd100,
     {OP_STORE, 8'd2}, 16'd7, {OP_JMP, 8'd0}, 16'd26 },
  '{ {OP_JMP, 8'd0}, 16'd8, 16'h0, 16'h0,
     16'h0, 16'h0, 16'h0, RESULT_MARK,
     {OP_IMM, 8'd1}, P3_VAL, {OP_STORE, 8'd1}, 16'd100,
     {OP_IMM, 8'd1}, 16'h0, 16'h0, 16'h0,
     16'h0, 16'h0, 16'h0, 16'h0,
     16'h0, 16'h0, {OP_LOAD, 8'd2}, 16'd100,
     {OP_STORE, 8'd2}, 16'd7, {OP_JMP, 8'd0}, 16'd26 }
};

// logical data addresses each program touches, unused slots are 0
localparam log_addr_t DATA_ADDRS [N_PROC][4] = '{
  '{8'd5, 8'd0, 8'd0, 8'd0},
  '{8'd100, 8'd200, 8'd23, 8'd6},
  '{8'd100, 8'd7, 8'd0, 8'd0},
  '{8'd100, 8'd7, 8'd0, 8'd0}
};

`endif

/* bench/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  import cpu_pkg::*;

  `include "cpu_tb_programs.svh"

  localparam int RUN_CYCLES     = 1500;
  localparam int TIMEOUT_CYCLES = 4000;  // run window plus program load, readback and margin
  localparam int N_SCRATCH      = 4;
  localparam int SCRATCH_WORD   = 1000;  // page 31, never allocated here

  logic        clka;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [12:0] paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;

  int    seed = 32'h89eecb04;
  int    cycles = 0;
  word_t rd;
  word_t scratch [N_SCRATCH];

  cpu_top uut (
    .clka(clka), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #10 clka = ~clka;

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) stop_with_failure("timeout, the test did not finish in time");
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  function automatic logic [12:0] word_paddr(input int w);
    return 13'(w * 4);  // byte address of a memory word
  endfunction

  task automatic apb_xfer(input logic wr, input logic [12:0] addr, input word_t wdata,
                          output word_t data, output logic err, output int waits);
    @(posedge clka);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clka);
    #1;
    penable = 1'b1;
    waits   = 0;
    @(negedge clka);  // sample mid-cycle
    while (!pready) begin
      waits++;
      if (waits > 8) stop_with_failure("an APB transfer never completed");
      @(negedge clka);
    end
    data = prdata;
    err  = pslverr;
    @(posedge clka);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [12:0] addr, input word_t data, input logic exp_err);
    word_t ignored;
    logic  err;
    int    waits;
    apb_xfer(1'b1, addr, data, ignored, err, waits);
    assert (err === exp_err) else stop_with_failure(
      $sformatf("Error: pslverr at paddr 0x%h is 0x%h, expected 0x%h", addr, err, exp_err));
    assert (waits == 0) else stop_with_failure("a write was held in a wait state");
  endtask

  task automatic apb_read(input logic [12:0] addr, output word_t data);
    logic err;
    int   waits;
    int   exp_waits;
    exp_waits = (addr < MEM_WINDOW_LIMIT) ? 1 : 0;  // the ram adds one wait state
    apb_xfer(1'b0, addr, 16'h0000, data, err, waits);
    assert (!err) else stop_with_failure(
      $sformatf("Error: pslverr on read at paddr 0x%h is 0x%h, expected 0x0", addr, err));
    assert (waits == exp_waits) else stop_with_failure($sformatf(
      "read at paddr 0x%h took %0d wait states instead of %0d", addr, waits, exp_waits));
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else
      stop_with_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_mem(input int w, input word_t exp);
    word_t data;
    apb_read(word_paddr(w), data);
    check_word($sformatf("prdata for memory word 0x%h", 10'(w)), data, exp);
  endtask

  task automatic load_programs();
    for (int p = 0; p < N_PROC; p++) begin
      for (int w = 0; w < PROG_LEN; w++) begin
        apb_write(word_paddr(p * PAGE_WORDS + w), PROGS[p][w], 1'b0);
      end
    end
  endtask

  // distinct non-zero logical pages per process, summed
  function automatic int count_alloc_pages();
    int                  total;
    logic [N_LPAGES-1:0] touched;
    total = 0;
    for (int p = 0; p < N_PROC; p++) begin
      touched = '0;
      for (int k = 0; k < 4; k++) begin
        touched[DATA_ADDRS[p][k][LOG_W-1:OFF_W]] = 1'b1;
      end
      touched[0] = 1'b0;  // page 0 is reserved
      total += $countones(touched);
    end
    return total;
  endfunction

  initial begin
    clka    = 1'b0;
    rst     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (2) @(posedge clka);
    #1;
    rst = 1'b1;

    apb_read(REG_STATUS, rd);
    check_word("prdata for REG_STATUS", rd, 16'h0000);
    apb_read(REG_CTRL, rd);
    check_word("prdata for REG_CTRL", rd, 16'h0000);
    for (int i = 0; i < N_SCRATCH; i++) begin
      scratch[i] = word_t'($random(seed));
      apb_write(word_paddr(SCRATCH_WORD + i), scratch[i], 1'b0);
    end
    for (int i = 0; i < N_SCRATCH; i++) begin
      check_mem(SCRATCH_WORD + i, scratch[i]);
    end

    load_programs();
    apb_write(REG_CTRL, 16'h0001, 1'b0);
    apb_read(REG_CTRL, rd);
    check_word("prdata for REG_CTRL", rd, 16'h0001);
    apb_read(REG_STATUS, rd);
    check_word("prdata[0] for REG_STATUS", word_t'(rd[0]), 16'h0001);
    apb_write(word_paddr(SCRATCH_WORD), word_t'($random(seed)), 1'b1);  // core owns the ram

    repeat (RUN_CYCLES) @(posedge clka);
    apb_write(REG_CTRL, 16'h0000, 1'b0);
    do begin
      apb_read(REG_STATUS, rd);
    end while (rd[0]);

    check_word("prdata for REG_STATUS", rd, word_t'(count_alloc_pages() << 8));
    check_mem(5, word_t'(P0_VALUE + P0_ADD - P0_SUB));
    check_mem(4, SKIP_MARK);
    check_mem(PAGE_WORDS + 6, word_t'(P1_A + P1_B));
    check_mem(2 * PAGE_WORDS + 7, P2_VAL);
    check_mem(3 * PAGE_WORDS + 7, P3_VAL);
    check_mem(SCRATCH_WORD, scratch[0]);  // rejected write left it alone

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* design/apb_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
  input  wire                       clka,
  input  wire                       rst,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [12:0]                paddr,
  input  wire cpu_pkg::word_t       pwdata,
  output cpu_pkg::word_t            prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  wire                       busy,
  input  wire cpu_pkg::page_t       alloc_count,
  output logic                      run,
  input  wire                       core_en,
  input  wire                       core_we,
  input  wire cpu_pkg::phys_addr_t  core_addr,
  input  wire cpu_pkg::word_t       core_wdata,
  output logic                      mem_en,
  output logic                      mem_we,
  output cpu_pkg::phys_addr_t       mem_addr,
  output cpu_pkg::word_t            mem_wdata,
  input  wire cpu_pkg::word_t       mem_rdata
);

  import cpu_pkg::*;

  logic       access;
  logic       is_mem;
  logic       is_ctrl;
  logic       is_status;
  logic       mem_err;
  logic       host_en;
  logic       host_we;
  logic       rd_pend;     // memory read issued, data valid this cycle
  phys_addr_t host_addr;

  assign access    = psel && penable;
  assign is_mem    = paddr < MEM_WINDOW_LIMIT;
  assign is_ctrl   = paddr == REG_CTRL;
  assign is_status = paddr == REG_STATUS;
  assign mem_err   = is_mem && busy;  // memory belongs to the core while it runs

  assign host_en   = access && is_mem && !busy && (pwrite || !rd_pend);
  assign host_we   = access && is_mem && !busy && pwrite;
  assign host_addr = paddr[$bits(phys_addr_t)+1:2];  // byte address to word

  assign mem_en    = busy ? core_en : host_en;
  assign mem_we    = busy ? core_we : host_we;
  assign mem_addr  = busy ? core_addr : host_addr;
  assign mem_wdata = busy ? core_wdata : pwdata;

  // only an accepted memory read waits for the ram
  assign pready  = access && (pwrite || !is_mem || mem_err || rd_pend);
  assign pslverr = pready && (mem_err || !(is_mem || is_ctrl || is_status));

  always_comb begin
    prdata = '0;
    if (rd_pend) begin
      prdata = mem_rdata;
    end else if (is_ctrl) begin
      prdata[0] = run;
    end else if (is_status) begin
      prdata[0]           = busy;
      prdata[8 +: PAGE_W] = alloc_count;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      rd_pend <= 1'b0;
      run     <= 1'b0;
    end else begin
      rd_pend <= host_en && !pwrite;
      if (access && pwrite && is_ctrl) run <= pwdata[0];  // 0 asks for a stop
    end
  end

endmodule

`default_nettype wire

/* design/block_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module block_ram (
  input  wire                       clka,
  input  wire                       en,
  input  wire                       we,
  input  wire cpu_pkg::phys_addr_t  addr,
  input  wire cpu_pkg::word_t       wdata,
  output cpu_pkg::word_t            rdata
);

  import cpu_pkg::*;

  word_t ram [MEM_WORDS];

  always_ff @(posedge clka) begin
    if (en) begin
      if (we) ram[addr] <= wdata;
      rdata <= ram[addr];  // old contents on a write
    end
  end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // sizes
  localparam int N_PROC     = 4;
  localparam int N_REGS     = 8;     // registers per process
  localparam int PAGE_WORDS = 32;
  localparam int N_PAGES    = 32;    // physical pages in the shared memory
  localparam int SLICE_LEN  = 8;     // instructions before a process switch

  localparam int WORD_W    = 16;
  localparam int LOG_W     = 8;      // logical address is the operand low byte
  localparam int OFF_W     = $clog2(PAGE_WORDS);
  localparam int PAGE_W    = $clog2(N_PAGES);
  localparam int LPAGE_W   = LOG_W - OFF_W;
  localparam int N_LPAGES  = 2 ** LPAGE_W;
  localparam int MEM_WORDS = N_PAGES * PAGE_WORDS;

  typedef logic [WORD_W-1:0]          word_t;
  typedef logic [PAGE_W+OFF_W-1:0]    phys_addr_t;
  typedef logic [LOG_W-1:0]           log_addr_t;
  typedef logic [PAGE_W-1:0]          page_t;
  typedef logic [LPAGE_W-1:0]         lpage_t;
  typedef logic [$clog2(N_REGS)-1:0]  reg_idx_t;
  typedef logic [$clog2(N_PROC)-1:0]  proc_idx_t;
  typedef logic [7:0]                 opcode_t;

  typedef enum logic [3:0] {
    S_IDLE,
    S_F1_XLAT,    // translate pc for the opcode word
    S_F1_WAIT,
    S_F2_XLAT,    // translate pc+1 for the operand word
    S_F2_WAIT,
    S_EXEC,
    S_LD_XLAT,
    S_LD_WAIT,
    S_ST_XLAT     // store is issued when translation completes
  } seq_state_t;

  // opcodes, high byte of the first instruction word
  localparam opcode_t OP_JMP   = 8'd1;
  localparam opcode_t OP_LOAD  = 8'd2;
  localparam opcode_t OP_STORE = 8'd3;
  localparam opcode_t OP_IMM   = 8'd4;
  localparam opcode_t OP_ADD   = 8'd5;
  localparam opcode_t OP_SUB   = 8'd6;

  // APB map
  localparam logic [12:0] REG_CTRL         = 13'h1000;
  localparam logic [12:0] REG_STATUS       = 13'h1004;
  localparam logic [12:0] MEM_WINDOW_LIMIT = 13'h1000;  // below this is the memory window

endpackage

`default_nettype wire

/* design/cpu_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_seq (
  input  wire                        clka,
  input  wire                        rst,
  input  wire                        run,
  output logic                       busy,
  output cpu_pkg::proc_idx_t         active_proc,
  output logic [cpu_pkg::N_PROC-1:0] ctx_sel,
  output logic                       pc_we,
  output cpu_pkg::log_addr_t         pc_next,
  output logic                       reg_we,
  output cpu_pkg::reg_idx_t          wr_reg,
  output cpu_pkg::word_t             wr_data,
  input  wire [cpu_pkg::N_PROC*cpu_pkg::LOG_W-1:0]                   pc_in,
  input  wire [cpu_pkg::N_PROC*cpu_pkg::N_REGS*cpu_pkg::WORD_W-1:0]  regs_in,
  output logic                       xlat_req,
  output cpu_pkg::log_addr_t         xlat_addr,
  input  wire                        xlat_done,
  input  wire cpu_pkg::phys_addr_t   phys_addr,
  output logic                       mem_en,
  output logic                       mem_we,
  output cpu_pkg::phys_addr_t        mem_addr,
  output cpu_pkg::word_t             mem_wdata,
  input  wire cpu_pkg::word_t        mem_rdata
);

  import cpu_pkg::*;

  seq_state_t state;
  opcode_t    op;
  reg_idx_t   ir_reg;
  word_t      operand;
  log_addr_t  pc_cur;
  word_t      reg_cur;
  logic       instr_end;
  logic [$clog2(SLICE_LEN)-1:0] slice_cnt;

  assign pc_cur  = pc_in[active_proc*LOG_W +: LOG_W];
  assign reg_cur = regs_in[(active_proc*N_REGS + ir_reg)*WORD_W +: WORD_W];
  assign busy    = (state != S_IDLE);
  assign ctx_sel = N_PROC'(1) << active_proc;

  // request stays up until the mapper answers
  always_comb begin
    xlat_req  = 1'b0;
    xlat_addr = operand[LOG_W-1:0];
    case (state)
      S_F1_XLAT: begin
        xlat_req  = 1'b1;
        xlat_addr = pc_cur;
      end
      S_F2_XLAT: begin
        xlat_req  = 1'b1;
        xlat_addr = pc_cur + 8'd1;
      end
      S_LD_XLAT, S_ST_XLAT: xlat_req = 1'b1;
      default: ;
    endcase
  end

  assign mem_en    = xlat_done;  // every translation ends in an access
  assign mem_we    = xlat_done && (state == S_ST_XLAT);
  assign mem_addr  = phys_addr;
  assign mem_wdata = reg_cur;

  assign pc_we   = (state == S_EXEC);
  assign pc_next = (op == OP_JMP) ? operand[LOG_W-1:0] : pc_cur + 8'd2;
  assign wr_reg  = ir_reg;

  always_comb begin
    reg_we  = 1'b0;
    wr_data = operand;
    if (state == S_LD_WAIT) begin
      reg_we  = 1'b1;
      wr_data = mem_rdata;
    end else if (state == S_EXEC) begin
      case (op)
        OP_IMM: reg_we = 1'b1;
        OP_ADD: begin
          reg_we  = 1'b1;
          wr_data = reg_cur + operand;
        end
        OP_SUB: begin
          reg_we  = 1'b1;
          wr_data = reg_cur - operand;
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (state)
      S_EXEC:    instr_end = (op != OP_LOAD) && (op != OP_STORE);
      S_LD_WAIT: instr_end = 1'b1;
      S_ST_XLAT: instr_end = xlat_done;
      default:   instr_end = 1'b0;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= S_IDLE;
    end else if (instr_end) begin
      state <= run ? S_F1_XLAT : S_IDLE;  // stop only between instructions
    end else begin
      case (state)
        S_IDLE:    if (run) state <= S_F1_XLAT;
        S_F1_XLAT: if (xlat_done) state <= S_F1_WAIT;
        S_F1_WAIT: state <= S_F2_XLAT;
        S_F2_XLAT: if (xlat_done) state <= S_F2_WAIT;
        S_F2_WAIT: state <= S_EXEC;
        S_EXEC:    state <= (op == OP_LOAD) ? S_LD_XLAT : S_ST_XLAT;
        S_LD_XLAT: if (xlat_done) state <= S_LD_WAIT;
        default:   state <= state;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == S_F1_WAIT) begin
      op     <= mem_rdata[15:8];
      ir_reg <= mem_rdata[$bits(reg_idx_t)-1:0];
    end
    if (state == S_F2_WAIT) operand <= mem_rdata;
  end

  // round-robin time slice
  always_ff @(posedge clka) begin
    if (!rst) begin
      slice_cnt   <= '0;
      active_proc <= '0;
    end else if (instr_end) begin
      if (slice_cnt == SLICE_LEN - 1) begin
        slice_cnt   <= '0;
        active_proc <= active_proc + 1'b1;  // wraps modulo N_PROC
      end else begin
        slice_cnt <= slice_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire                   clka,
  input  wire                   rst,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire [12:0]            paddr,
  input  wire cpu_pkg::word_t   pwdata,
  output cpu_pkg::word_t        prdata,
  output logic                  pready,
  output logic                  pslverr
);

  import cpu_pkg::*;

  logic       run;
  logic       busy;
  page_t      alloc_count;
  logic       core_en;
  logic       core_we;
  phys_addr_t core_addr;
  word_t      core_wdata;
  logic       mem_en;
  logic       mem_we;
  phys_addr_t mem_addr;
  word_t      mem_wdata;
  word_t      mem_rdata;

  proc_idx_t         active_proc;
  logic [N_PROC-1:0] ctx_sel;
  logic              pc_we;
  log_addr_t         pc_next;
  logic              reg_we;
  reg_idx_t          wr_reg;
  word_t             wr_data;

  logic       xlat_req;
  log_addr_t  xlat_addr;
  logic       xlat_done;
  phys_addr_t phys_addr;
  logic       pt_we;
  lpage_t     pt_lpage;
  page_t      pt_page;

  wire [N_PROC*LOG_W-1:0]           pc_all;
  wire [N_PROC*N_REGS*WORD_W-1:0]   regs_all;
  wire [N_PROC*N_LPAGES*PAGE_W-1:0] pt_flat_all;
  wire [N_PROC*N_LPAGES-1:0]        pt_valid_all;

  apb_host_port u_apb (
    .clka(clka), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .busy(busy), .alloc_count(alloc_count), .run(run),
    .core_en(core_en), .core_we(core_we), .core_addr(core_addr), .core_wdata(core_wdata),
    .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

  block_ram u_ram (
    .clka(clka), .en(mem_en), .we(mem_we), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata)
  );

  cpu_seq u_seq (
    .clka(clka), .rst(rst), .run(run), .busy(busy),
    .active_proc(active_proc), .ctx_sel(ctx_sel),
    .pc_we(pc_we), .pc_next(pc_next), .reg_we(reg_we), .wr_reg(wr_reg), .wr_data(wr_data),
    .pc_in(pc_all), .regs_in(regs_all),
    .xlat_req(xlat_req), .xlat_addr(xlat_addr), .xlat_done(xlat_done), .phys_addr(phys_addr),
    .mem_en(core_en), .mem_we(core_we), .mem_addr(core_addr), .mem_wdata(core_wdata),
    .mem_rdata(mem_rdata)
  );

  page_mapper u_mapper (
    .clka(clka), .rst(rst), .active_proc(active_proc),
    .pt_flat_all(pt_flat_all), .pt_valid_all(pt_valid_all),
    .xlat_req(xlat_req), .xlat_addr(xlat_addr), .xlat_done(xlat_done), .phys_addr(phys_addr),
    .pt_we(pt_we), .pt_lpage(pt_lpage), .pt_page(pt_page), .alloc_count(alloc_count)
  );

  for (genvar i = 0; i < N_PROC; i++) begin : g_ctx
    proc_context u_ctx (
      .clka(clka), .rst(rst), .init_page(page_t'(i)), .sel(ctx_sel[i]),
      .pc_we(pc_we), .pc_next(pc_next),
      .reg_we(reg_we), .wr_reg(wr_reg), .wr_data(wr_data),
      .pt_we(pt_we), .pt_lpage(pt_lpage), .pt_page(pt_page),
      .pc(pc_all[i*LOG_W +: LOG_W]),
      .regs_flat(regs_all[i*N_REGS*WORD_W +: N_REGS*WORD_W]),
      .pt_flat(pt_flat_all[i*N_LPAGES*PAGE_W +: N_LPAGES*PAGE_W]),
      .pt_valid(pt_valid_all[i*N_LPAGES +: N_LPAGES])
    );
  end

endmodule

`default_nettype wire

/* design/page_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module page_mapper (
  input  wire                        clka,
  input  wire                        rst,
  input  wire cpu_pkg::proc_idx_t    active_proc,
  input  wire [cpu_pkg::N_PROC*cpu_pkg::N_LPAGES*cpu_pkg::PAGE_W-1:0]  pt_flat_all,
  input  wire [cpu_pkg::N_PROC*cpu_pkg::N_LPAGES-1:0]                  pt_valid_all,
  input  wire                        xlat_req,
  input  wire cpu_pkg::log_addr_t    xlat_addr,
  output logic                       xlat_done,
  output cpu_pkg::phys_addr_t        phys_addr,
  output logic                       pt_we,
  output cpu_pkg::lpage_t            pt_lpage,
  output cpu_pkg::page_t             pt_page,
  output cpu_pkg::page_t             alloc_count
);

  import cpu_pkg::*;

  lpage_t           lpage;
  logic [OFF_W-1:0] offset;
  page_t            tbl_page;
  logic             tbl_valid;
  logic             alloc;
  page_t            free_next;

  assign lpage     = xlat_addr[LOG_W-1:OFF_W];
  assign offset    = xlat_addr[OFF_W-1:0];
  assign tbl_page  = pt_flat_all[(active_proc*N_LPAGES + lpage)*PAGE_W +: PAGE_W];
  assign tbl_valid = pt_valid_all[active_proc*N_LPAGES + lpage];

  // first touch: allocate now, answer next cycle while pt_we is up
  assign alloc     = xlat_req && !tbl_valid && !pt_we;
  assign xlat_done = xlat_req && (tbl_valid || pt_we);
  assign phys_addr = {(pt_we ? pt_page : tbl_page), offset};

  assign alloc_count = free_next - page_t'(N_PROC);

  always_ff @(posedge clka) begin
    if (!rst) begin
      pt_we     <= 1'b0;
      free_next <= page_t'(N_PROC);  // pages below are the reserved page 0s
    end else begin
      pt_we <= alloc;
      if (alloc) free_next <= free_next + 1'b1;  // reaches 0 after the last page
    end
  end

  always_ff @(posedge clka) begin
    if (alloc) begin
      pt_lpage <= lpage;
      pt_page  <= free_next;
    end
  end

endmodule

`default_nettype wire

/* design/proc_context.sv */
`timescale 1ns/1ps
`default_nettype none

module proc_context (
  input  wire                        clka,
  input  wire                        rst,
  input  wire cpu_pkg::page_t        init_page,
  input  wire                        sel,
  input  wire                        pc_we,
  input  wire cpu_pkg::log_addr_t    pc_next,
  input  wire                        reg_we,
  input  wire cpu_pkg::reg_idx_t     wr_reg,
  input  wire cpu_pkg::word_t        wr_data,
  input  wire                        pt_we,
  input  wire cpu_pkg::lpage_t       pt_lpage,
  input  wire cpu_pkg::page_t        pt_page,
  output cpu_pkg::log_addr_t         pc,
  output logic [cpu_pkg::N_REGS*cpu_pkg::WORD_W-1:0]    regs_flat,
  output logic [cpu_pkg::N_LPAGES*cpu_pkg::PAGE_W-1:0]  pt_flat,
  output logic [cpu_pkg::N_LPAGES-1:0]                  pt_valid
);

  import cpu_pkg::*;

  word_t regs [N_REGS];
  page_t pt   [N_LPAGES];

  always_ff @(posedge clka) begin
    if (!rst) begin
      pc       <= '0;
      pt_valid <= N_LPAGES'(1);  // logical page 0 is always mapped
      for (int i = 0; i < N_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (sel) begin
      if (pc_we) pc <= pc_next;
      if (reg_we) regs[wr_reg] <= wr_data;
      if (pt_we) pt_valid[pt_lpage] <= 1'b1;
    end
  end

  // entry 0 points at the reserved page of this process
  always_ff @(posedge clka) begin
    if (!rst) begin
      pt[0] <= init_page;
    end else if (sel && pt_we) begin
      pt[pt_lpage] <= pt_page;
    end
  end

  always_comb begin
    for (int i = 0; i < N_REGS; i++) begin
      regs_flat[i*WORD_W +: WORD_W] = regs[i];
    end
    for (int j = 0; j < N_LPAGES; j++) begin
      pt_flat[j*PAGE_W +: PAGE_W] = pt[j];
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+bench
design/cpu_pkg.sv
design/block_ram.sv
design/apb_host_port.sv
design/proc_context.sv
design/cpu_seq.sv
design/page_mapper.sv
design/cpu_top.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f filelist.f

sim_out=$(./obj_dir/Vcpu_tb) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
echo "simulation did not pass"
exit 1
